// ==== hdl/rv_pkg.sv ====
// rv64 widths, word types, opcode and funct codes, alu operation and source enums
package rv_pkg;

  // architectural widths
  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;

  typedef logic [XLEN-1:0]        xlen_t;     // data, pc, imm, target
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 codes
  localparam logic [2:0] F3_ADD    = 3'b000;   // addi, add, sub
  localparam logic [2:0] F3_BEQ    = 3'b000;
  localparam logic [2:0] F3_BNE    = 3'b001;
  localparam logic [2:0] F3_DOUBLE = 3'b011;   // ld / sd width

  // funct7 codes for the reg-reg group
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_PASS_B = 3'd2    // lui, second operand straight through
  } alu_op_e;

  typedef enum logic {
    SRC2_RS2 = 1'b0,
    SRC2_IMM = 1'b1
  } alu_src2_e;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

// ==== hdl/id_pkg.sv ====
// packed bus structs around the decode stage: fetch, execute, branch, write-back, bypass
package id_pkg;

  // fetch -> decode
  typedef struct packed {
    rv_pkg::xlen_t pc;
    rv_pkg::inst_t inst;
  } fs_to_ds_t;

  // control fields carried down the pipe with each instruction
  typedef struct packed {
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::alu_src2_e alu_src2;
    logic              gpr_wen;
    logic              mem_ren;
    logic              mem_wen;
    logic              load_sel;   // ld, execute needs this for the load-use stall
    logic              invalid;    // outside the supported subset
  } ctrl_t;

  // decode -> execute
  typedef struct packed {
    ctrl_t             ctrl;
    rv_pkg::xlen_t     rs1data;    // already forwarded
    rv_pkg::xlen_t     rs2data;
    rv_pkg::xlen_t     imm;
    rv_pkg::xlen_t     pc;
    rv_pkg::gpr_addr_t rd;
  } ds_to_es_t;

  // decode -> fetch
  typedef struct packed {
    logic          stall;          // taken but operands not ready yet
    logic          taken;
    rv_pkg::xlen_t target;
  } br_t;

  // write-back -> register file
  typedef struct packed {
    logic              wen;
    rv_pkg::gpr_addr_t waddr;
    rv_pkg::xlen_t     wdata;
  } wb_t;

  // result offered back to decode by a later stage
  // rd of zero means the stage has nothing to forward
  typedef struct packed {
    rv_pkg::gpr_addr_t rd;
    rv_pkg::xlen_t     result;
  } bypass_t;

endpackage

// ==== hdl/inst_decoder.sv ====
// instruction decoder for lui, addi, add, sub, ld, sd, beq, bne and jal
`timescale 1ns/1ps

module inst_decoder (
  input  rv_pkg::inst_t     i_inst,
  output rv_pkg::gpr_addr_t o_rs1,
  output rv_pkg::gpr_addr_t o_rs2,
  output rv_pkg::gpr_addr_t o_rd,
  output rv_pkg::xlen_t     o_imm,
  output id_pkg::ctrl_t     o_ctrl,
  output logic              o_br_en,   // beq / bne
  output logic              o_br_ne,   // compare for inequality
  output logic              o_jal
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  rv_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;
  logic          legal;
  logic          is_branch;
  logic          is_jal;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  // all immediates sign-extended from inst[31]
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    legal           = 1'b0;
    is_branch       = 1'b0;
    is_jal          = 1'b0;
    o_imm           = '0;
    o_ctrl.alu_op   = rv_pkg::ALU_ADD;
    o_ctrl.alu_src2 = rv_pkg::SRC2_RS2;
    o_ctrl.gpr_wen  = 1'b0;
    o_ctrl.mem_ren  = 1'b0;
    o_ctrl.mem_wen  = 1'b0;
    o_ctrl.load_sel = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        legal           = 1'b1;
        o_imm           = imm_u;
        o_ctrl.alu_op   = rv_pkg::ALU_PASS_B;
        o_ctrl.alu_src2 = rv_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        legal           = (funct3 == rv_pkg::F3_ADD);
        o_imm           = imm_i;
        o_ctrl.alu_src2 = rv_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      rv_pkg::OPC_OP: begin
        legal          = (funct3 == rv_pkg::F3_ADD) &&
                         (funct7 == rv_pkg::F7_ADD || funct7 == rv_pkg::F7_SUB);
        o_ctrl.gpr_wen = 1'b1;
        if (funct7 == rv_pkg::F7_SUB) begin
          o_ctrl.alu_op = rv_pkg::ALU_SUB;
        end
      end
      rv_pkg::OPC_LOAD: begin
        legal           = (funct3 == rv_pkg::F3_DOUBLE);
        o_imm           = imm_i;          // address = rs1 + imm
        o_ctrl.alu_src2 = rv_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.load_sel = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        legal           = (funct3 == rv_pkg::F3_DOUBLE);
        o_imm           = imm_s;
        o_ctrl.alu_src2 = rv_pkg::SRC2_IMM;
        o_ctrl.mem_wen  = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        legal     = (funct3 == rv_pkg::F3_BEQ) || (funct3 == rv_pkg::F3_BNE);
        o_imm     = imm_b;
        is_branch = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        legal  = 1'b1;
        o_imm  = imm_j;
        is_jal = 1'b1;    // link write is not part of this datapath
      end
      default: legal = 1'b0;
    endcase
    // nothing architectural may happen for an illegal word
    if (!legal) begin
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.mem_ren  = 1'b0;
      o_ctrl.mem_wen  = 1'b0;
      o_ctrl.load_sel = 1'b0;
    end
    o_ctrl.invalid = ~legal;
  end

  // rd only when the instruction really writes, keeps later bypass rds clean
  assign o_rd    = o_ctrl.gpr_wen ? i_inst[11:7] : '0;
  assign o_br_en = is_branch & legal;
  assign o_br_ne = (funct3 == rv_pkg::F3_BNE);
  assign o_jal   = is_jal;

endmodule

// ==== hdl/gpr_file.sv ====
// general-purpose register file, two async read ports and one write port
`timescale 1ns/1ps

module gpr_file #(
  parameter int NUM_GPRS = 32        // 16 for rv64e
) (
  input  logic              i_clk,
  input  logic              i_reset,
  input  rv_pkg::gpr_addr_t i_raddr1,
  input  rv_pkg::gpr_addr_t i_raddr2,
  output rv_pkg::xlen_t     o_rdata1,
  output rv_pkg::xlen_t     o_rdata2,
  input  id_pkg::wb_t       i_wb
);

  rv_pkg::xlen_t regs [NUM_GPRS];

  // x0 and indices past the array read as zero
  function automatic rv_pkg::xlen_t rd_port(input rv_pkg::gpr_addr_t addr);
    rd_port = (addr != '0 && int'(addr) < NUM_GPRS) ? regs[addr] : '0;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_GPRS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.waddr != '0 && int'(i_wb.waddr) < NUM_GPRS) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // no write-through, same-cycle writes come in over the ws bypass
  assign o_rdata1 = rd_port(i_raddr1);
  assign o_rdata2 = rd_port(i_raddr2);

endmodule

// ==== hdl/operand_bypass.sv ====
// source operand forwarding from execute, memory and write-back
`timescale 1ns/1ps

module operand_bypass (
  input  rv_pkg::gpr_addr_t i_rs1,
  input  rv_pkg::gpr_addr_t i_rs2,
  input  rv_pkg::xlen_t     i_rf_data1,
  input  rv_pkg::xlen_t     i_rf_data2,
  input  id_pkg::bypass_t   i_es_bypass,
  input  id_pkg::bypass_t   i_ms_bypass,
  input  id_pkg::bypass_t   i_ws_bypass,
  output rv_pkg::xlen_t     o_rs1data,
  output rv_pkg::xlen_t     o_rs2data
);

  // a stage hits when it carries a real rd equal to the source
  function automatic logic hit(input id_pkg::bypass_t byp,
                               input rv_pkg::gpr_addr_t src);
    hit = (byp.rd != '0) && (byp.rd == src);
  endfunction

  // youngest result wins: es, then ms, then ws
  function automatic rv_pkg::xlen_t pick(input rv_pkg::gpr_addr_t src,
                                         input rv_pkg::xlen_t     rf_data);
    if (hit(i_es_bypass, src)) begin
      pick = i_es_bypass.result;
    end else if (hit(i_ms_bypass, src)) begin
      pick = i_ms_bypass.result;
    end else if (hit(i_ws_bypass, src)) begin
      pick = i_ws_bypass.result;
    end else begin
      pick = rf_data;
    end
  endfunction

  assign o_rs1data = pick(i_rs1, i_rf_data1);
  assign o_rs2data = pick(i_rs2, i_rf_data2);

endmodule

// ==== hdl/branch_unit.sv ====
// branch compare and jump target for beq, bne and jal
`timescale 1ns/1ps

module branch_unit (
  input  rv_pkg::xlen_t i_pc,
  input  rv_pkg::xlen_t i_imm,
  input  rv_pkg::xlen_t i_rs1data,    // forwarded values
  input  rv_pkg::xlen_t i_rs2data,
  input  logic          i_br_en,
  input  logic          i_br_ne,
  input  logic          i_jal,
  output logic          o_taken,
  output rv_pkg::xlen_t o_target
);

  logic operands_eq;
  logic cond_met;

  assign operands_eq = (i_rs1data == i_rs2data);
  assign cond_met    = i_br_ne ? ~operands_eq : operands_eq;   // bne flips beq

  // jal is unconditional
  assign o_taken  = i_jal | (i_br_en & cond_met);

  // pc relative for both branch and jal
  assign o_target = i_pc + i_imm;

endmodule

// ==== hdl/id_stage.sv ====
// decode stage top: stage register, valid/allowin handshake, load stall, sub-blocks
`timescale 1ns/1ps

module id_stage #(
  parameter int NUM_GPRS = 32
) (
  input  logic              i_clk,
  input  logic              i_reset,
  // fetch side
  input  logic              i_fs_valid,
  input  id_pkg::fs_to_ds_t i_fs_bus,
  output logic              o_ds_allowin,
  // execute side
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es_bus,
  // redirect to fetch
  output id_pkg::br_t       o_br,
  // register write from write-back
  input  id_pkg::wb_t       i_wb,
  // hazard inputs
  input  logic              i_es_load_sel,
  input  id_pkg::bypass_t   i_es_bypass,
  input  id_pkg::bypass_t   i_ms_bypass,
  input  id_pkg::bypass_t   i_ws_bypass
);

  logic              ds_valid;
  logic              ds_ready_go;
  logic              load_stall;
  id_pkg::fs_to_ds_t fs_bus_r;

  rv_pkg::gpr_addr_t rs1, rs2, rd;
  rv_pkg::xlen_t     imm;
  id_pkg::ctrl_t     ctrl;
  logic              br_en, br_ne, jal;
  rv_pkg::xlen_t     rf_data1, rf_data2;
  rv_pkg::xlen_t     rs1data, rs2data;
  logic              bu_taken;
  rv_pkg::xlen_t     bu_target;

  // load in execute produces its data one stage too late for us
  assign load_stall = i_es_load_sel && (i_es_bypass.rd != '0) &&
                      ((i_es_bypass.rd == rs1) || (i_es_bypass.rd == rs2));

  assign ds_ready_go      = ~load_stall;
  assign o_ds_allowin     = ~ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = ds_valid & ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      fs_bus_r <= i_fs_bus;   // held while stalled or back-pressured
    end
  end

  inst_decoder u_decoder (
    .i_inst   (fs_bus_r.inst),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .o_rd     (rd),
    .o_imm    (imm),
    .o_ctrl   (ctrl),
    .o_br_en  (br_en),
    .o_br_ne  (br_ne),
    .o_jal    (jal)
  );

  gpr_file #(
    .NUM_GPRS (NUM_GPRS)
  ) u_gprs (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_data1),
    .o_rdata2 (rf_data2),
    .i_wb     (i_wb)
  );

  operand_bypass u_bypass (
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_rf_data1  (rf_data1),
    .i_rf_data2  (rf_data2),
    .i_es_bypass (i_es_bypass),
    .i_ms_bypass (i_ms_bypass),
    .i_ws_bypass (i_ws_bypass),
    .o_rs1data   (rs1data),
    .o_rs2data   (rs2data)
  );

  branch_unit u_bru (
    .i_pc      (fs_bus_r.pc),
    .i_imm     (imm),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_br_en   (br_en),
    .i_br_ne   (br_ne),
    .i_jal     (jal),
    .o_taken   (bu_taken),
    .o_target  (bu_target)
  );

  always_comb begin
    o_ds_to_es_bus.ctrl    = ctrl;
    o_ds_to_es_bus.rs1data = rs1data;
    o_ds_to_es_bus.rs2data = rs2data;
    o_ds_to_es_bus.imm     = imm;
    o_ds_to_es_bus.pc      = fs_bus_r.pc;
    o_ds_to_es_bus.rd      = rd;
  end

  // an empty stage never redirects fetch
  assign o_br.taken  = ds_valid & bu_taken;
  assign o_br.stall  = o_br.taken & load_stall;   // compare used stale operands
  assign o_br.target = bu_target;

endmodule

// ==== sim/tb_ref.svh ====
// reference models for decode, operand forwarding and branch resolution, plus the compare task
`ifndef TB_REF_SVH
`define TB_REF_SVH

// newest in-flight result for a source register, else the shadow register value
function automatic rv_pkg::xlen_t fwd_value(input rv_pkg::gpr_addr_t src,
                                            input rv_pkg::xlen_t rf,
                                            input id_pkg::bypass_t es,
                                            input id_pkg::bypass_t ms,
                                            input id_pkg::bypass_t ws);
  if (src == 5'd0) return '0;        // x0 is never forwarded
  if (es.rd == src) return es.result;
  if (ms.rd == src) return ms.result;
  if (ws.rd == src) return ws.result;
  return rf;
endfunction

function automatic id_pkg::ds_to_es_t expect_bus(input rv_pkg::inst_t inst,
                                                 input rv_pkg::xlen_t pc,
                                                 input rv_pkg::xlen_t rf1,
                                                 input rv_pkg::xlen_t rf2,
                                                 input id_pkg::bypass_t es,
                                                 input id_pkg::bypass_t ms,
                                                 input id_pkg::bypass_t ws);
  id_pkg::ds_to_es_t e;
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       legal;
  opc = inst[6:0];
  f3 = inst[14:12];
  f7 = inst[31:25];
  legal = 1'b0;
  e = '0;
  e.pc = pc;
  e.ctrl.alu_op = rv_pkg::ALU_ADD;
  e.ctrl.alu_src2 = rv_pkg::SRC2_RS2;
  case (opc)
    rv_pkg::OPC_LUI: begin
      legal = 1'b1;
      e.imm = {{32{inst[31]}}, inst[31:12], 12'h000};
      e.ctrl.alu_op = rv_pkg::ALU_PASS_B;
      e.ctrl.alu_src2 = rv_pkg::SRC2_IMM;
      e.ctrl.gpr_wen = 1'b1;
    end
    rv_pkg::OPC_OP_IMM: begin
      legal = (f3 == 3'b000);
      e.imm = {{52{inst[31]}}, inst[31:20]};
      e.ctrl.alu_src2 = rv_pkg::SRC2_IMM;
      e.ctrl.gpr_wen = 1'b1;
    end
    rv_pkg::OPC_OP: begin
      legal = (f3 == 3'b000) && (f7 == 7'h00 || f7 == 7'h20);
      e.ctrl.gpr_wen = 1'b1;
      if (f7 == 7'h20) e.ctrl.alu_op = rv_pkg::ALU_SUB;
    end
    rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE: begin
      legal = (f3 == 3'b011);
      e.ctrl.alu_src2 = rv_pkg::SRC2_IMM;
      e.ctrl.gpr_wen = (opc == rv_pkg::OPC_LOAD);
      e.ctrl.mem_ren = (opc == rv_pkg::OPC_LOAD);
      e.ctrl.load_sel = (opc == rv_pkg::OPC_LOAD);
      e.ctrl.mem_wen = (opc == rv_pkg::OPC_STORE);
      e.imm = (opc == rv_pkg::OPC_LOAD) ? {{52{inst[31]}}, inst[31:20]} :
                                          {{52{inst[31]}}, inst[31:25], inst[11:7]};
    end
    rv_pkg::OPC_BRANCH: begin
      legal = (f3 == 3'b000) || (f3 == 3'b001);
      e.imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    end
    rv_pkg::OPC_JAL: begin
      legal = 1'b1;
      e.imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    default: legal = 1'b0;
  endcase
  if (!legal) begin
    e.ctrl.gpr_wen = 1'b0;
    e.ctrl.mem_ren = 1'b0;
    e.ctrl.mem_wen = 1'b0;
    e.ctrl.load_sel = 1'b0;
  end
  e.ctrl.invalid = ~legal;
  e.rd = e.ctrl.gpr_wen ? inst[11:7] : 5'd0;
  e.rs1data = fwd_value(inst[19:15], rf1, es, ms, ws);
  e.rs2data = fwd_value(inst[24:20], rf2, es, ms, ws);
  return e;
endfunction

// branch result from the expected operands, stall only when a load hazard is present
function automatic id_pkg::br_t expect_br(input rv_pkg::inst_t inst,
                                          input id_pkg::ds_to_es_t e,
                                          input logic hazard);
  id_pkg::br_t b;
  logic        eq;
  eq = (e.rs1data == e.rs2data);
  b.taken = (inst[6:0] == rv_pkg::OPC_JAL) ||
            (inst[6:0] == rv_pkg::OPC_BRANCH &&
             ((inst[14:12] == 3'b000 && eq) || (inst[14:12] == 3'b001 && !eq)));
  b.stall = b.taken & hazard;
  b.target = e.pc + e.imm;
  return b;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
    err_cnt++;
  end
endtask

`endif

// ==== sim/tb_id_stage.sv ====
// decode stage testbench with clock, stimulus, output compare, timeout and summary
`timescale 1ns/1ps

module tb_id_stage;

  localparam int MAX_CYCLES = 400;   // six tests of about 40 cycles plus margin

  logic              clk;
  logic              reset;
  logic              fs_valid;
  id_pkg::fs_to_ds_t fs_bus;
  logic              ds_allowin;
  logic              es_allowin;
  logic              ds_to_es_valid;
  id_pkg::ds_to_es_t ds_to_es_bus;
  id_pkg::br_t       br;
  id_pkg::wb_t       wb;
  logic              es_load_sel;
  id_pkg::bypass_t   es_byp, ms_byp, ws_byp;

  rv_pkg::xlen_t shadow [32];
  rv_pkg::inst_t held_inst;
  rv_pkg::xlen_t held_pc;
  int            err_cnt, xfer_cnt, cycle_cnt, tests_failed, test_start;

  `include "tb_ref.svh"

  id_stage #(.NUM_GPRS(32)) dut (
    .i_clk (clk), .i_reset (reset),
    .i_fs_valid (fs_valid), .i_fs_bus (fs_bus), .o_ds_allowin (ds_allowin),
    .i_es_allowin (es_allowin), .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus (ds_to_es_bus), .o_br (br), .i_wb (wb),
    .i_es_load_sel (es_load_sel), .i_es_bypass (es_byp),
    .i_ms_bypass (ms_byp), .i_ws_bypass (ws_byp)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // compare each offered instruction against the model
  always @(posedge clk) begin : compare_outputs
    id_pkg::ds_to_es_t e;
    id_pkg::br_t       b;
    if (!reset && ds_to_es_valid) begin
      e = expect_bus(held_inst, held_pc, shadow[held_inst[19:15]], shadow[held_inst[24:20]],
                     es_byp, ms_byp, ws_byp);
      b = expect_br(held_inst, e, 1'b0);
      check_value("ctrl.invalid", 64'(ds_to_es_bus.ctrl.invalid), 64'(e.ctrl.invalid));
      check_value("ctrl.gpr_wen", 64'(ds_to_es_bus.ctrl.gpr_wen), 64'(e.ctrl.gpr_wen));
      check_value("ctrl.mem_ren", 64'(ds_to_es_bus.ctrl.mem_ren), 64'(e.ctrl.mem_ren));
      check_value("ctrl.mem_wen", 64'(ds_to_es_bus.ctrl.mem_wen), 64'(e.ctrl.mem_wen));
      check_value("ctrl.load_sel", 64'(ds_to_es_bus.ctrl.load_sel), 64'(e.ctrl.load_sel));
      if (!e.ctrl.invalid) begin  // op fields only defined for the subset
        check_value("ctrl.alu_op", 64'(ds_to_es_bus.ctrl.alu_op), 64'(e.ctrl.alu_op));
        check_value("ctrl.alu_src2", 64'(ds_to_es_bus.ctrl.alu_src2), 64'(e.ctrl.alu_src2));
        check_value("imm", ds_to_es_bus.imm, e.imm);
      end
      check_value("rd", 64'(ds_to_es_bus.rd), 64'(e.rd));
      check_value("pc", ds_to_es_bus.pc, e.pc);
      check_value("rs1data", ds_to_es_bus.rs1data, e.rs1data);
      check_value("rs2data", ds_to_es_bus.rs2data, e.rs2data);
      check_value("br.taken", 64'(br.taken), 64'(b.taken));
      check_value("br.stall", 64'(br.stall), 64'(b.stall));
      check_value("br.target", br.target, b.target);
      if (es_allowin) xfer_cnt++;
    end
  end

  // fetch handshake that returns one cycle after the stage took the word
  task automatic issue(input rv_pkg::inst_t inst, input rv_pkg::xlen_t pc);
    @(negedge clk);
    fs_valid = 1'b1;
    fs_bus.pc = pc;
    fs_bus.inst = inst;
    do @(posedge clk); while (!ds_allowin);
    @(negedge clk);
    fs_valid = 1'b0;
    held_inst = inst;
    held_pc = pc;
    @(negedge clk);
  endtask

  task automatic write_reg(input rv_pkg::gpr_addr_t addr, input rv_pkg::xlen_t data);
    @(negedge clk);
    wb = '{wen: 1'b1, waddr: addr, wdata: data};
    @(negedge clk);
    wb.wen = 1'b0;
    if (addr != 5'd0) shadow[addr] = data;   // x0 stays zero
  endtask

  task automatic end_test(input string name);
    if (err_cnt != test_start) tests_failed++;
    $display("test %s: %s (%0d mismatches)", name,
             (err_cnt == test_start) ? "ok" : "FAILED", err_cnt - test_start);
    test_start = err_cnt;
  endtask

  function automatic rv_pkg::inst_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input int rd);
    return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), rv_pkg::OPC_OP};
  endfunction

  function automatic rv_pkg::inst_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input logic [12:0] im);
    return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_pkg::inst_t rand_inst();
    logic [31:0] r;
    logic [11:0] i12;
    r = $urandom;
    i12 = r[31:20];
    case ($urandom_range(0, 6))
      0: return {r[31:12], r[11:7], rv_pkg::OPC_LUI};
      1: return {i12, r[19:15], 3'b000, r[11:7], rv_pkg::OPC_OP_IMM};
      2: return r_type(7'h00, int'(r[24:20]), int'(r[19:15]), int'(r[11:7]));
      3: return r_type(7'h20, int'(r[24:20]), int'(r[19:15]), int'(r[11:7]));
      4: return {i12, r[19:15], 3'b011, r[11:7], rv_pkg::OPC_LOAD};
      5: return {i12[11:5], r[24:20], r[19:15], 3'b011, i12[4:0], rv_pkg::OPC_STORE};
      default: begin
        case (r[1:0])   // opcodes outside the subset
          2'd0: return {r[31:7], 7'h17};
          2'd1: return {r[31:7], 7'h67};
          2'd2: return {r[31:7], 7'h73};
          default: return {r[31:7], 7'h0f};
        endcase
      end
    endcase
  endfunction

  initial begin : run_tests
    rv_pkg::xlen_t     va, vb;
    rv_pkg::gpr_addr_t r;
    id_pkg::ds_to_es_t snap;
    int                xfer0;
    void'($urandom(61));
    clk = 1'b0;
    reset = 1'b1;
    fs_valid = 1'b0;
    fs_bus = '0;
    es_allowin = 1'b1;
    wb = '0;
    es_load_sel = 1'b0;
    es_byp = '0;
    ms_byp = '0;
    ws_byp = '0;
    held_inst = rv_pkg::NOP_INST;
    held_pc = '0;
    err_cnt = 0;
    xfer_cnt = 0;
    cycle_cnt = 0;
    tests_failed = 0;
    test_start = 0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_value("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd0);
    check_value("br.taken", 64'(br.taken), 64'd0);
    check_value("br.stall", 64'(br.stall), 64'd0);
    check_value("o_ds_allowin", 64'(ds_allowin), 64'd1);
    end_test("reset");

    xfer0 = xfer_cnt;
    for (int i = 0; i < 24; i++) issue(rand_inst(), 64'h1000 + 64'(4 * i));
    check_value("decode transfers", 64'(xfer_cnt - xfer0), 64'd24);
    end_test("decode");

    write_reg(5'd0, 64'hdead_beef_0000_0001);
    for (int i = 0; i < 5; i++) begin
      r = 5'($urandom_range(1, 31));
      write_reg(r, {$urandom, $urandom});
      issue(r_type(7'h00, int'(r), 0, 1), 64'h2000);
      issue(r_type(7'h20, 0, int'(r), 2), 64'h2004);
    end
    issue(r_type(7'h00, 0, 0, 3), 64'h2008);
    end_test("register file");

    r = 5'd9;
    es_byp = '{rd: r, result: 64'haaaa};
    ms_byp = '{rd: r, result: 64'hbbbb};
    ws_byp = '{rd: r, result: 64'hcccc};
    issue(r_type(7'h00, 9, 9, 1), 64'h3000);
    es_byp.rd = 5'd0;
    issue(r_type(7'h00, 9, 9, 1), 64'h3004);
    ms_byp.rd = 5'd0;
    issue(r_type(7'h00, 9, 9, 1), 64'h3008);
    ws_byp.rd = 5'd0;
    issue(r_type(7'h00, 9, 9, 1), 64'h300c);
    issue(r_type(7'h00, 0, 0, 1), 64'h3010);   // rd zero offered with results
    end_test("bypass priority");

    es_load_sel = 1'b1;
    es_byp = '{rd: 5'd5, result: 64'h55};
    xfer0 = xfer_cnt;
    issue(b_type(3'b000, 5, 5, 13'h0040), 64'h4000);
    repeat (3) begin
      @(negedge clk);
      check_value("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd0);
      check_value("br.stall", 64'(br.stall), 64'd1);
      check_value("br.taken", 64'(br.taken), 64'd1);   // x5 equals x5 either way
    end
    @(negedge clk);
    es_load_sel = 1'b0;
    repeat (3) @(negedge clk);
    check_value("load stall transfers", 64'(xfer_cnt - xfer0), 64'd1);
    es_byp = '0;
    es_allowin = 1'b0;
    xfer0 = xfer_cnt;
    issue(r_type(7'h20, 8, 7, 6), 64'h4100);
    snap = ds_to_es_bus;
    repeat (3) begin
      @(negedge clk);
      check_value("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd1);
      check_value("o_ds_allowin", 64'(ds_allowin), 64'd0);
      if (ds_to_es_bus !== snap) begin
        $display("output bus changed while execute was not accepting");
        err_cnt++;
      end
    end
    es_allowin = 1'b1;
    repeat (3) @(negedge clk);
    check_value("back-pressure transfers", 64'(xfer_cnt - xfer0), 64'd1);
    end_test("stall and back-pressure");

    va = {$urandom, $urandom};
    vb = va ^ 64'h10;
    ws_byp = '{rd: 5'd3, result: va};
    ms_byp = '{rd: 5'd4, result: va};
    issue(b_type(3'b000, 3, 4, 13'h1ff0), 64'h5000);   // beq equal
    issue(b_type(3'b001, 3, 4, 13'h0100), 64'h5004);   // bne equal
    ms_byp.result = vb;
    issue(b_type(3'b000, 3, 4, 13'h0020), 64'h5008);   // beq unequal
    issue(b_type(3'b001, 3, 4, 13'h1000), 64'h500c);   // bne unequal
    issue({1'b1, 10'h3fe, 1'b0, 8'hff, 5'd1, rv_pkg::OPC_JAL}, 64'h5010);
    issue({1'b0, 10'h010, 1'b1, 8'h02, 5'd0, rv_pkg::OPC_JAL}, 64'h5014);
    ws_byp = '0;
    ms_byp = '0;
    end_test("branch and jal");

    $display("tests failed %0d of 6, mismatches %0d, transfers %0d",
             tests_failed, err_cnt, xfer_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+sim
hdl/rv_pkg.sv
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/gpr_file.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/id_stage.sv
sim/tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
